//--- cplx_pe.f
design/cplx_pe_pkg.sv
design/pe_issue_if.sv
design/pe_inst_mem.sv
design/pe_control.sv
design/pe_data_mem.sv
design/complex_alu.sv
design/pe.sv
verif/pe_asserts.sv
verif/pe_tb.sv

//--- Makefile
# Verilator build and run for cplx_pe

VERILATOR ?= verilator
TOP       ?= pe_tb
FILELIST  ?= cplx_pe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/pe_tb.sv
`timescale 1ns/1ps

module pe_tb import cplx_pe_pkg::*; ();

    localparam int reg_num      = 8;
    localparam int imem_depth   = 16;
    localparam int cyc_per_inst = 40;   // timeout budget per executed instruction
    localparam int margin       = 1000; // reset, loads and idle time

    logic        clk;
    logic        rst_n;
    logic        din_pe_v;
    logic [31:0] din_pe;
    logic        inst_in_v;
    logic [15:0] inst_in;
    logic        start;
    logic        dout_pe_v;
    logic [31:0] dout_pe;
    logic        dout_fwd_v;
    logic [31:0] dout_fwd;
    logic        busy;

    logic [31:0] lcg_state;
    cplx_t       model_regs [reg_num]; // reference copy of the register file
    inst_t       prog [imem_depth];
    int          prog_len;
    logic [31:0] exp_pe [$];
    logic [31:0] exp_fwd [$];

    int errors, checks, tests_run, tests_failed;
    int n_pe, n_fwd;      // results seen in the current test
    int cycles, exec_total;

    pe #(.reg_num(reg_num), .imem_depth(imem_depth)) i_pe (
        .clk        (clk),
        .rst_n      (rst_n),
        .din_pe_v   (din_pe_v),
        .din_pe     (din_pe),
        .inst_in_v  (inst_in_v),
        .inst_in    (inst_in),
        .start      (start),
        .dout_pe_v  (dout_pe_v),
        .dout_pe    (dout_pe),
        .dout_fwd_v (dout_fwd_v),
        .dout_fwd   (dout_fwd),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    ////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int pick(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[31:16]) % n; // upper bits, better spread
    endfunction

    function automatic opcode_t rand_alu_op();
        case (pick(4))
            0:       return op_cadd;
            1:       return op_csub;
            2:       return op_cmul;
            default: return op_conj;
        endcase
    endfunction

    function automatic inst_t make_alu(input opcode_t op, input int dst, input int a,
                                       input int b, input logic out_en, input logic fwd_en);
        inst_t w;
        w            = '0;
        w.alu.op     = op;
        w.alu.dst    = reg_addr_w'(dst);
        w.alu.src_a  = reg_addr_w'(a);
        w.alu.src_b  = reg_addr_w'(b);
        w.alu.out_en = out_en;
        w.alu.fwd_en = fwd_en;
        return w;
    endfunction

    function automatic inst_t make_ctl(input opcode_t op, input int count, input int target);
        inst_t w;
        w            = '0;
        w.ctl.op     = op;
        w.ctl.count  = 4'(count);
        w.ctl.target = pc_w'(target);
        return w;
    endfunction

    // complex arithmetic, each part wraps to 16 bits
    function automatic cplx_t model_alu(input opcode_t op, input cplx_t a, input cplx_t b);
        int    ar, ai, br, bi, re, im;
        cplx_t res;
        ar = a.re;
        ai = a.im;
        br = b.re;
        bi = b.im;
        case (op)
            op_cadd: begin
                re = ar + br;
                im = ai + bi;
            end
            op_csub: begin
                re = ar - br;
                im = ai - bi;
            end
            op_cmul: begin
                re = ar * br - ai * bi;
                im = ar * bi + ai * br;
            end
            default: begin // conj
                re = ar;
                im = -ai;
            end
        endcase
        res.re = re[15:0];
        res.im = im[15:0];
        return res;
    endfunction

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR: %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////
    // reference model, walks the program in order
    ////////////////////////////////////////////////////
    task automatic model_program();
        int    pc, left, steps;
        logic  act;
        inst_t w;
        cplx_t res;
        pc    = 0;
        left  = 0;
        steps = 0;
        act   = 1'b0;
        while (pc < imem_depth) begin // past the end acts as halt
            w = prog[pc];
            steps++;
            case (w.alu.op)
                op_halt: pc = imem_depth;
                op_nop:  pc++;
                op_loop: begin
                    if (!act && w.ctl.count != 4'd0) begin
                        act  = 1'b1; // first pass arms the count
                        left = int'(w.ctl.count) - 1;
                        pc   = int'(w.ctl.target);
                    end else if (act && left != 0) begin
                        left--;
                        pc = int'(w.ctl.target);
                    end else begin
                        act = 1'b0;
                        pc++;
                    end
                end
                default: begin
                    res = model_alu(w.alu.op, model_regs[w.alu.src_a], model_regs[w.alu.src_b]);
                    model_regs[w.alu.dst] = res;
                    if (w.alu.out_en) exp_pe.push_back(res);
                    if (w.alu.fwd_en) exp_fwd.push_back(res);
                    pc++;
                end
            endcase
        end
        exec_total += steps; // widens the timeout
    endtask

    ////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////
    task automatic load_regs();
        cplx_t v;
        for (int i = 0; i < reg_num; i++) begin
            v             = next_rand();
            model_regs[i] = v;
            @(posedge clk);
            din_pe_v <= 1'b1;
            din_pe   <= v;
        end
        @(posedge clk);
        din_pe_v <= 1'b0;
    endtask

    task automatic load_prog();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            inst_in_v <= 1'b1;
            inst_in   <= prog[i];
        end
        @(posedge clk);
        inst_in_v <= 1'b0;
    endtask

    task automatic report_test(input string name, input int err0);
        tests_run++;
        if (errors != err0) tests_failed++;
        $display("test %0d %s: %0d on dout_pe, %0d on dout_fwd, %s", tests_run, name,
                 n_pe, n_fwd, (errors == err0) ? "ok" : "mismatch");
    endtask

    task automatic idle_test();
        int err0;
        err0  = errors;
        n_pe  = 0;
        n_fwd = 0;
        repeat (10) begin
            @(negedge clk);
            check_val("busy", 32'(busy), 32'd0);
            check_val("dout_pe_v", 32'(dout_pe_v), 32'd0);
            check_val("dout_fwd_v", 32'(dout_fwd_v), 32'd0);
        end
        report_test("idle after reset", err0);
    endtask

    // load, start, wait for busy to drop, then look for leftovers
    task automatic run_program(input string name);
        int err0;
        err0  = errors;
        n_pe  = 0;
        n_fwd = 0;
        load_regs();
        load_prog();
        model_program();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        if (!busy) begin
            $display("busy did not rise after start in test %s", name);
            errors++;
        end
        while (busy) @(negedge clk); // watchdog bounds this
        @(negedge clk);
        if (exp_pe.size() != 0 || exp_fwd.size() != 0) begin
            $display("%0d dout_pe and %0d dout_fwd results never came in test %s",
                     exp_pe.size(), exp_fwd.size(), name);
            errors++;
            exp_pe.delete();
            exp_fwd.delete();
        end
        report_test(name, err0);
    endtask

    ////////////////////////////////////////////////////
    // monitors and watchdog
    ////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst_n && dout_pe_v) begin
            if (exp_pe.size() == 0) begin
                $display("unexpected word %h on dout_pe at %0t ns", dout_pe, $time);
                errors++;
            end else begin
                check_val("dout_pe", dout_pe, exp_pe.pop_front());
            end
            n_pe++;
        end
        if (rst_n && dout_fwd_v) begin
            if (exp_fwd.size() == 0) begin
                $display("unexpected word %h on dout_fwd at %0t ns", dout_fwd, $time);
                errors++;
            end else begin
                check_val("dout_fwd", dout_fwd, exp_fwd.pop_front());
            end
            n_fwd++;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > margin + cyc_per_inst * exec_total) begin
            $display("timeout: the run did not finish within %0d cycles", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////
    initial begin
        lcg_state    = 32'h2e72_ef31;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycles       = 0;
        exec_total   = 0;
        rst_n     <= 1'b0;
        din_pe_v  <= 1'b0;
        din_pe    <= '0;
        inst_in_v <= 1'b0;
        inst_in   <= '0;
        start     <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        idle_test();

        // independent add and subtract, results to dout_pe
        prog_len = 9;
        for (int i = 0; i < 8; i++) begin
            prog[i] = make_alu((pick(2) == 0) ? op_cadd : op_csub, 4 + i % 4, pick(4), pick(4),
                               1'b1, 1'b0);
        end
        prog[8] = make_ctl(op_halt, 0, 0);
        run_program("add and sub");

        // multiply and conjugate with wraparound
        prog_len = 9;
        for (int i = 0; i < 8; i++) begin
            prog[i] = make_alu((pick(2) == 0) ? op_cmul : op_conj, 4 + i % 4, pick(4), pick(4),
                               1'b1, 1'b0);
        end
        prog[8] = make_ctl(op_halt, 0, 0);
        run_program("mul and conj");

        // each step reads the one before, scoreboard must stall
        prog_len = 11;
        prog[0]  = make_alu(rand_alu_op(), 0, pick(8), pick(8), 1'b1, 1'b0);
        for (int i = 1; i < 10; i++) begin
            prog[i] = make_alu(rand_alu_op(), pick(8), prog[i-1].alu.dst, pick(8), 1'b1, 1'b0);
        end
        prog[10] = make_ctl(op_halt, 0, 0);
        run_program("dependent chain");

        // body 0..2 runs count+1 times
        prog_len = 5;
        prog[0]  = make_alu(op_cmul, 1, 1, 2, 1'b1, 1'b0); // feeds back, each pass differs
        prog[1]  = make_alu(op_cadd, 3, 1, 3, 1'b1, 1'b1);
        prog[2]  = make_ctl(op_loop, 1 + pick(6), 0);
        prog[3]  = make_alu(op_csub, 4, 3, 1, 1'b1, 1'b0);
        prog[4]  = make_ctl(op_halt, 0, 0);
        run_program("counted loop");

        // random routing to either port, both or neither
        prog_len = 13;
        for (int i = 0; i < 12; i++) begin
            prog[i] = make_alu(rand_alu_op(), pick(8), pick(8), pick(8), 1'(pick(2)), 1'(pick(2)));
        end
        prog[12] = make_ctl(op_halt, 0, 0);
        run_program("output routing");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verif/pe_asserts.sv
`timescale 1ns/1ps

module pe_asserts import cplx_pe_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic dout_pe_v,
    input logic dout_fwd_v,
    input logic iss_valid,
    input logic wb_valid
);

    // quiet while in reset
    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !busy && !dout_pe_v && !dout_fwd_v)
        else $error("busy or an output strobe is high during reset");

    a_wb_after_iss: assert property (@(posedge clk) disable iff (!rst_n)
        iss_valid |-> ##alu_lat wb_valid)
        else $error("issue without a writeback alu_lat cycles later");

    a_wb_from_iss: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> $past(iss_valid, alu_lat)) // no stray writebacks
        else $error("writeback without a matching issue");

    a_iss_busy: assert property (@(posedge clk) disable iff (!rst_n) iss_valid |-> busy)
        else $error("issue while the element is idle");

endmodule

bind pe pe_asserts i_pe_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .busy       (busy),
    .dout_pe_v  (dout_pe_v),
    .dout_fwd_v (dout_fwd_v),
    .iss_valid  (iss_bus.iss_valid),
    .wb_valid   (iss_bus.wb_valid)
);

//--- design/pe.sv
`timescale 1ns/1ps

module pe import cplx_pe_pkg::*; #(
    parameter int reg_num    = 8,
    parameter int imem_depth = 16
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      din_pe_v,
    input  logic [2*data_w-1:0]       din_pe,
    input  logic                      inst_in_v,
    input  logic [$bits(inst_t)-1:0]  inst_in,
    input  logic                      start,
    output logic                      dout_pe_v,
    output logic [2*data_w-1:0]       dout_pe,
    output logic                      dout_fwd_v,
    output logic [2*data_w-1:0]       dout_fwd,
    output logic                      busy
);

    logic [pc_w-1:0]       fetch_addr;
    inst_t                 fetch_inst;
    logic                  rd_en;
    logic [reg_addr_w-1:0] rd_addr_a, rd_addr_b;
    cplx_t                 rd_data_a, rd_data_b;
    logic                  load_clear;

    pe_issue_if iss_bus ();

    ////////////////////////////////////////////////////
    // blocks
    ////////////////////////////////////////////////////
    pe_inst_mem #(.imem_depth(imem_depth)) u_inst_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_v     (inst_in_v && !busy), // no loads while running
        .load_inst  (inst_in),
        .clear      (load_clear),
        .fetch_addr (fetch_addr),
        .fetch_inst (fetch_inst)
    );

    pe_control #(.reg_num(reg_num), .imem_depth(imem_depth)) u_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .fetch_addr (fetch_addr),
        .fetch_inst (fetch_inst),
        .rd_en      (rd_en),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .load_clear (load_clear),
        .busy       (busy),
        .iss        (iss_bus.ctrl)
    );

    pe_data_mem #(.reg_num(reg_num)) u_data_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_v     (din_pe_v && !busy),
        .load_data  (din_pe),
        .load_clear (load_clear),
        .rd_en      (rd_en),
        .rd_addr_a  (rd_addr_a),
        .rd_addr_b  (rd_addr_b),
        .rd_data_a  (rd_data_a),
        .rd_data_b  (rd_data_b),
        .wb         (iss_bus.mem)
    );

    complex_alu u_alu (
        .clk   (clk),
        .rst_n (rst_n),
        .op_a  (rd_data_a),
        .op_b  (rd_data_b),
        .alu   (iss_bus.alu)
    );

    // output strobes, one cycle after writeback
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout_pe_v  <= 1'b0;
            dout_fwd_v <= 1'b0;
        end else begin
            dout_pe_v  <= iss_bus.wb_valid && iss_bus.wb_out;
            dout_fwd_v <= iss_bus.wb_valid && iss_bus.wb_fwd;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_bus.wb_valid && iss_bus.wb_out) begin
            dout_pe <= iss_bus.wb_data;
        end
        if (iss_bus.wb_valid && iss_bus.wb_fwd) begin
            dout_fwd <= iss_bus.wb_data; // same word, second port
        end
    end

endmodule

//--- design/complex_alu.sv
`timescale 1ns/1ps

module complex_alu import cplx_pe_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  cplx_t  op_a,
    input  cplx_t  op_b,
    pe_issue_if.alu alu
);

    localparam int prod_w = 2 * data_w;

    // tags ride along with the data
    logic [alu_lat-1:0]    v_pipe;
    logic [alu_lat-1:0]    out_pipe;
    logic [alu_lat-1:0]    fwd_pipe;
    logic [reg_addr_w-1:0] dst_pipe [alu_lat];

    opcode_t s1_op;
    cplx_t   s1_a;
    cplx_t   s1_b;

    // re = p_re0 - p_re1, im = p_im0 + p_im1
    logic signed [prod_w-1:0] p_re0, p_re1, p_im0, p_im1;
    cplx_t                    s3_res;

    function automatic logic signed [prod_w-1:0] sx(input logic signed [data_w-1:0] v);
        return v; // sign extend
    endfunction

    ////////////////////////////////////////////////////
    // tag pipeline
    ////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_pipe <= '0;
        end else begin
            v_pipe <= {v_pipe[alu_lat-2:0], alu.iss_valid};
        end
    end

    always_ff @(posedge clk) begin
        out_pipe    <= {out_pipe[alu_lat-2:0], alu.iss_out};
        fwd_pipe    <= {fwd_pipe[alu_lat-2:0], alu.iss_fwd};
        dst_pipe[0] <= alu.iss_dst;
        for (int i = 1; i < alu_lat; i++) begin
            dst_pipe[i] <= dst_pipe[i-1];
        end
    end

    // stage 1, capture operands
    always_ff @(posedge clk) begin
        if (alu.iss_valid) begin
            s1_op <= alu.iss_op;
            s1_a  <= op_a;
            s1_b  <= op_b;
        end
    end

    // stage 2, part products or sums
    always_ff @(posedge clk) begin
        if (v_pipe[0]) begin
            p_re0 <= '0;
            p_re1 <= '0;
            p_im0 <= '0;
            p_im1 <= '0;
            case (s1_op)
                op_cadd: begin
                    p_re0 <= sx(s1_a.re) + sx(s1_b.re);
                    p_im0 <= sx(s1_a.im) + sx(s1_b.im);
                end
                op_csub: begin
                    p_re0 <= sx(s1_a.re) - sx(s1_b.re);
                    p_im0 <= sx(s1_a.im) - sx(s1_b.im);
                end
                op_cmul: begin
                    p_re0 <= sx(s1_a.re) * sx(s1_b.re); // ar*br
                    p_re1 <= sx(s1_a.im) * sx(s1_b.im); // ai*bi
                    p_im0 <= sx(s1_a.re) * sx(s1_b.im); // ar*bi
                    p_im1 <= sx(s1_a.im) * sx(s1_b.re); // ai*br
                end
                op_conj: begin
                    p_re0 <= sx(s1_a.re);
                    p_im0 <= -sx(s1_a.im);
                end
                default: ; // nothing else reaches the ALU
            endcase
        end
    end

    // stage 3, combine and wrap to 16 bits per part
    always_ff @(posedge clk) begin
        if (v_pipe[1]) begin
            s3_res.re <= data_w'(p_re0 - p_re1);
            s3_res.im <= data_w'(p_im0 + p_im1);
        end
    end

    assign alu.wb_valid = v_pipe[alu_lat-1];
    assign alu.wb_dst   = dst_pipe[alu_lat-1];
    assign alu.wb_out   = out_pipe[alu_lat-1];
    assign alu.wb_fwd   = fwd_pipe[alu_lat-1];
    assign alu.wb_data  = s3_res;

endmodule

//--- design/pe_data_mem.sv
`timescale 1ns/1ps

module pe_data_mem import cplx_pe_pkg::*; #(
    parameter int reg_num = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load_v,     // host operand, next slot
    input  cplx_t                 load_data,
    input  logic                  load_clear,
    input  logic                  rd_en,
    input  logic [reg_addr_w-1:0] rd_addr_a,
    input  logic [reg_addr_w-1:0] rd_addr_b,
    output cplx_t                 rd_data_a,  // one cycle after rd_en
    output cplx_t                 rd_data_b,
    pe_issue_if.mem               wb
);

    localparam int ptr_w = $clog2(reg_num) + 1;

    cplx_t            regs [reg_num];
    logic [ptr_w-1:0] load_ptr;
    logic             load_ok;
    logic             wb_ok;

    assign load_ok = load_v && (load_ptr < ptr_w'(reg_num)); // extra words dropped
    assign wb_ok   = wb.wb_valid && (int'(wb.wb_dst) < reg_num);

    ////////////////////////////////////////////////////
    // load pointer
    ////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_ptr <= '0;
        end else if (load_clear) begin
            load_ptr <= '0;
        end else if (load_ok) begin
            load_ptr <= load_ptr + 1'b1;
        end
    end

    ////////////////////////////////////////////////////
    // register file
    ////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wb_ok) begin
            regs[wb.wb_dst] <= wb.wb_data; // writeback has priority
        end else if (load_ok) begin
            regs[load_ptr[ptr_w-2:0]] <= load_data;
        end
    end

    // two registered read ports, no bypass
    // scoreboard keeps reads clear of a same-cycle writeback
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data_a <= regs[rd_addr_a];
            rd_data_b <= regs[rd_addr_b];
        end
    end

endmodule

//--- design/pe_control.sv
`timescale 1ns/1ps

module pe_control import cplx_pe_pkg::*; #(
    parameter int reg_num    = 8,
    parameter int imem_depth = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    output logic [pc_w-1:0]       fetch_addr,
    input  inst_t                 fetch_inst,
    output logic                  rd_en,
    output logic [reg_addr_w-1:0] rd_addr_a,
    output logic [reg_addr_w-1:0] rd_addr_b,
    output logic                  load_clear,
    output logic                  busy,
    pe_issue_if.ctrl              iss
);

    localparam int cnt_w = $clog2(alu_lat + 2);

    logic            run;       // fetching
    logic            dec_v;     // fetch_inst holds a live instruction
    logic [pc_w-1:0] dec_pc;    // address of fetch_inst
    logic            loop_act;
    logic [3:0]      loop_left;

    logic [cnt_w-1:0] pend [reg_num]; // writebacks in flight per register
    logic             any_pend;

    opcode_t dec_op;
    logic    is_alu, need_b, hazard, stall, issue;
    logic    take_jump, last_slot, stop;

    ////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////
    assign dec_op = fetch_inst.alu.op; // same bits in ctl view
    assign is_alu = dec_op inside {op_cadd, op_csub, op_cmul, op_conj};
    assign need_b = (dec_op != op_conj); // conj reads a only

    assign hazard = (pend[fetch_inst.alu.src_a] != '0)
                 || (need_b && (pend[fetch_inst.alu.src_b] != '0))
                 || (pend[fetch_inst.alu.dst] != '0); // keeps writebacks in order

    assign stall = dec_v && is_alu && hazard;
    assign issue = dec_v && is_alu && !hazard;

    // first visit arms the counter, later visits count it down
    assign take_jump = dec_v && (dec_op == op_loop)
                    && (loop_act ? (loop_left != 4'd0) : (fetch_inst.ctl.count != 4'd0));

    assign last_slot = (dec_pc == pc_w'(imem_depth - 1));
    assign stop      = dec_v && !stall && !take_jump
                    && ((dec_op == op_halt) || last_slot); // falling off the end = halt

    // next fetch, stall replays the same slot
    always_comb begin
        if (!dec_v) begin
            fetch_addr = '0; // first fetch after start
        end else if (stall) begin
            fetch_addr = dec_pc;
        end else if (take_jump) begin
            fetch_addr = fetch_inst.ctl.target;
        end else begin
            fetch_addr = dec_pc + 1'b1;
        end
    end

    assign rd_en      = issue;
    assign rd_addr_a  = fetch_inst.alu.src_a;
    assign rd_addr_b  = fetch_inst.alu.src_b;
    assign load_clear = start && !busy; // accepted start

    ////////////////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            run       <= 1'b0;
            dec_v     <= 1'b0;
            dec_pc    <= '0;
            loop_act  <= 1'b0;
            loop_left <= '0;
        end else if (load_clear) begin
            busy     <= 1'b1;
            run      <= 1'b1;
            dec_v    <= 1'b0;
            loop_act <= 1'b0;
        end else begin
            if (run) begin
                dec_v  <= !stop;
                dec_pc <= fetch_addr;
                if (stop) begin
                    run <= 1'b0;
                end
            end
            if (dec_v && (dec_op == op_loop)) begin
                if (!loop_act) begin
                    if (fetch_inst.ctl.count != 4'd0) begin
                        loop_act  <= 1'b1;
                        loop_left <= fetch_inst.ctl.count - 4'd1;
                    end
                end else if (loop_left == 4'd0) begin
                    loop_act <= 1'b0; // done, fall through
                end else begin
                    loop_left <= loop_left - 4'd1;
                end
            end
            if (busy && !run && !any_pend) begin
                busy <= 1'b0; // halted and drained
            end
        end
    end

    ////////////////////////////////////////////////////
    // scoreboard
    ////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_num; i++) begin
                pend[i] <= '0;
            end
        end else begin
            for (int i = 0; i < reg_num; i++) begin
                pend[i] <= pend[i]
                         + cnt_w'(issue && (fetch_inst.alu.dst == reg_addr_w'(i)))
                         - cnt_w'(iss.wb_valid && (iss.wb_dst == reg_addr_w'(i)));
            end
        end
    end

    always_comb begin
        any_pend = 1'b0;
        for (int i = 0; i < reg_num; i++) begin
            any_pend = any_pend | (pend[i] != '0);
        end
    end

    // issue tags line up with the operands out of the register file
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            iss.iss_valid <= 1'b0;
        end else begin
            iss.iss_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        iss.iss_op  <= dec_op;
        iss.iss_dst <= fetch_inst.alu.dst;
        iss.iss_out <= fetch_inst.alu.out_en;
        iss.iss_fwd <= fetch_inst.alu.fwd_en;
    end

endmodule

//--- design/pe_inst_mem.sv
`timescale 1ns/1ps

module pe_inst_mem import cplx_pe_pkg::*; #(
    parameter int imem_depth = 16
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            load_v,     // one instruction per cycle
    input  inst_t           load_inst,
    input  logic            clear,      // rewind load pointer
    input  logic [pc_w-1:0] fetch_addr,
    output inst_t           fetch_inst  // one cycle after fetch_addr
);

    // one spare bit so the pointer can sit past the end
    localparam int ptr_w = $clog2(imem_depth) + 1;

    inst_t            mem [imem_depth];
    logic [ptr_w-1:0] load_ptr;
    logic             load_ok;

    assign load_ok = load_v && (load_ptr < ptr_w'(imem_depth)); // drop overflow

    ////////////////////////////////////////////////////
    // load pointer
    ////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_ptr <= '0;
        end else if (clear) begin
            load_ptr <= '0;
        end else if (load_ok) begin
            load_ptr <= load_ptr + 1'b1; // saturates at imem_depth
        end
    end

    // program store
    always_ff @(posedge clk) begin
        if (load_ok) begin
            mem[load_ptr[ptr_w-2:0]] <= load_inst;
        end
    end

    // registered fetch, decoder sees it next cycle
    always_ff @(posedge clk) begin
        fetch_inst <= mem[fetch_addr];
    end

endmodule

//--- design/pe_issue_if.sv
`timescale 1ns/1ps

interface pe_issue_if import cplx_pe_pkg::*; ();

    // issue side, one cycle after the register read is requested
    logic                  iss_valid;
    opcode_t               iss_op;
    logic [reg_addr_w-1:0] iss_dst;
    logic                  iss_out;
    logic                  iss_fwd;

    // writeback side, alu_lat cycles after issue
    logic                  wb_valid;
    logic [reg_addr_w-1:0] wb_dst;
    cplx_t                 wb_data;
    logic                  wb_out;
    logic                  wb_fwd;

    modport ctrl (
        output iss_valid, iss_op, iss_dst, iss_out, iss_fwd,
        input  wb_valid, wb_dst // scoreboard release
    );

    modport alu (
        input  iss_valid, iss_op, iss_dst, iss_out, iss_fwd,
        output wb_valid, wb_dst, wb_data, wb_out, wb_fwd
    );

    modport mem (
        input wb_valid, wb_dst, wb_data
    );

endinterface

//--- design/cplx_pe_pkg.sv
package cplx_pe_pkg;

    ////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////
    localparam int data_w     = 16; // one real or imaginary part
    localparam int reg_addr_w = 3;  // 8 registers by default
    localparam int pc_w       = 4;  // 16 instruction slots by default
    localparam int alu_lat    = 3;  // ALU pipeline stages

    // complex word, re on top
    typedef struct packed {
        logic signed [data_w-1:0] re;
        logic signed [data_w-1:0] im;
    } cplx_t;

    typedef enum logic [2:0] {
        op_nop,
        op_cadd,
        op_csub,
        op_cmul,
        op_conj,
        op_loop,
        op_halt
    } opcode_t;

    ////////////////////////////////////////////////////
    // instruction formats
    ////////////////////////////////////////////////////
    typedef struct packed {
        opcode_t                op;
        logic [reg_addr_w-1:0] dst;
        logic [reg_addr_w-1:0] src_a;
        logic [reg_addr_w-1:0] src_b;
        logic                  out_en; // result to dout_pe
        logic                  fwd_en; // result to dout_fwd
        logic [1:0]            pad;
    } alu_fmt_t;

    typedef struct packed {
        opcode_t         op;
        logic [3:0]      count;  // extra passes through the body
        logic [pc_w-1:0] target; // loop start
        logic [4:0]      pad;
    } ctl_fmt_t;

    // opcode sits in the top 3 bits of both views
    typedef union packed {
        alu_fmt_t alu;
        ctl_fmt_t ctl;
    } inst_t;

endpackage
